/* hawk_tbl_config.svh */
// hawk table init build constants
// table bases, entry counts, packing and field widths
`ifndef HAWK_TBL_CONFIG_SVH
`define HAWK_TBL_CONFIG_SVH

// byte base addresses
`define HAWK_ATT_START   64'h0000_0000_1000_0000
`define HAWK_LIST_START  64'h0000_0000_1000_1000
`define HAWK_PPA_START   64'h0000_0000_2000_0000  // first page is this >> 12

// table sizes, multiples of the line packing
`define ATT_ENTRY_CNT    24
`define LIST_ENTRY_CNT   12
`define ATT_PER_LINE     8   // 8 bytes each in a 64 byte line
`define LIST_PER_LINE    4   // 16 bytes each

// bus and entry widths
`define LINE_BITS        512
`define STRB_BITS        64
`define ADDR_BITS        64
`define PTR_BITS         24  // list pointer, 0 is null
`define CNT_BITS         6
`define ATT_ENTRY_BITS   64
`define LIST_ENTRY_BITS  128
`define ATT_WAY_BITS     52  // att bits 55..4
`define LIST_WAY_BITS    42  // list bits 113..72

`endif

/* hawk_tbl_pkg.sv */
// hawk table init types
// controller states, init mode and att entry status
`default_nettype none

package hawk_tbl_pkg;

	// controller states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		INIT_ATT   = 3'd1,
		WAIT_ATT   = 3'd2,
		INIT_LIST  = 3'd3,
		WAIT_LIST  = 3'd4,
		WAIT_BRESP = 3'd5
	} ctrl_state_e;

	// which table is being written, picks the entry format
	typedef enum logic {
		MODE_ATT  = 1'b0,
		MODE_LIST = 1'b1
	} init_mode_e;

	// att entry status field, bits 3..0
	typedef enum logic [3:0] {
		STS_DALLOC = 4'd0,
		STS_UNCOMP = 4'd1,
		STS_COMP   = 4'd2,  // not produced at init
		STS_INCOMP = 4'd3   // not produced at init
	} att_sts_e;

endpackage

`default_nettype wire

/* tbl_line_builder.sv */
// table line builder
// turns a 1-based entry index into one single-slot write with its
// line address, slot data and byte strobe
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module tbl_line_builder
	import hawk_tbl_pkg::*;
#(
	parameter int PWRUP_UNCOMP = 0  // att entries come up uncompressed when 1
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   load,
	input  init_mode_e             mode,
	input  logic [`CNT_BITS-1:0]   entry_idx,
	output logic [`ADDR_BITS-1:0]  awaddr,
	output logic [`LINE_BITS-1:0]  wdata,
	output logic [`STRB_BITS-1:0]  wstrb
);

	localparam int ATT_SLOT_W  = $clog2(`ATT_PER_LINE);
	localparam int LIST_SLOT_W = $clog2(`LIST_PER_LINE);
	localparam int ATT_BYTES   = `ATT_ENTRY_BITS / 8;
	localparam int LIST_BYTES  = `LIST_ENTRY_BITS / 8;

	logic [`CNT_BITS-1:0]        idx0;       // 0-based index
	logic [`ADDR_BITS-1:0]       page;       // physical page number of this entry
	logic [`ADDR_BITS-1:0]       line_off;
	logic [ATT_SLOT_W-1:0]       att_slot;
	logic [LIST_SLOT_W-1:0]      list_slot;
	logic [`PTR_BITS-1:0]        prev_ptr;
	logic [`PTR_BITS-1:0]        next_ptr;
	logic [`ATT_ENTRY_BITS-1:0]  att_entry;
	logic [`LIST_ENTRY_BITS-1:0] list_entry;
	logic [`ADDR_BITS-1:0]       addr_d;
	logic [`LINE_BITS-1:0]       data_d;
	logic [`STRB_BITS-1:0]       strb_d;

	assign idx0      = entry_idx - `CNT_BITS'd1;
	assign page      = (`HAWK_PPA_START >> 12) + `ADDR_BITS'(idx0);  // 4KB pages
	assign att_slot  = idx0[ATT_SLOT_W-1:0];
	assign list_slot = idx0[LIST_SLOT_W-1:0];

	// entry 0 stands for null in the free list chain
	assign prev_ptr = `PTR_BITS'(idx0);  // first entry gets null
	assign next_ptr = (entry_idx == `CNT_BITS'(`LIST_ENTRY_CNT)) ? '0 :
		`PTR_BITS'(entry_idx) + `PTR_BITS'd1;

	// att entry {zero count, way, status}
	always_comb begin
		if (PWRUP_UNCOMP != 0) begin
			att_entry = {8'd0, page[`ATT_WAY_BITS-1:0], STS_UNCOMP};  // points at own page
		end else begin
			att_entry = {8'd0, {`ATT_WAY_BITS{1'b0}}, STS_DALLOC};
		end
	end

	// list entry {rsvd, way, att id, prev, next} with att id left zero at init
	assign list_entry = {14'd0, page[`LIST_WAY_BITS-1:0], `PTR_BITS'd0, prev_ptr, next_ptr};

	always_comb begin
		data_d = '0;
		strb_d = '0;
		if (mode == MODE_ATT) begin
			line_off = `ADDR_BITS'(idx0 >> ATT_SLOT_W) << 6;  // new line every 8 entries
			addr_d   = `HAWK_ATT_START + line_off;
			data_d[att_slot*`ATT_ENTRY_BITS +: `ATT_ENTRY_BITS] = att_entry;
			strb_d[att_slot*ATT_BYTES +: ATT_BYTES] = '1;
		end else begin
			line_off = `ADDR_BITS'(idx0 >> LIST_SLOT_W) << 6;  // every 4 entries
			addr_d   = `HAWK_LIST_START + line_off;
			data_d[list_slot*`LIST_ENTRY_BITS +: `LIST_ENTRY_BITS] = list_entry;
			strb_d[list_slot*LIST_BYTES +: LIST_BYTES] = '1;
		end
	end

	// captured address and strobe
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awaddr <= '0;
			wstrb  <= '0;
		end else if (load) begin
			awaddr <= addr_d;
			wstrb  <= strb_d;
		end
	end

	// line payload
	always_ff @(posedge clk_i) begin
		if (load) begin
			wdata <= data_d;
		end
	end

endmodule

`default_nettype wire

/* wr_resp_tracker.sv */
// write response tracker
// counts writes in flight, flags bad or unexpected responses
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module wr_resp_tracker (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       awvalid,
	input  logic       awready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       drained,
	output logic       bus_error
);

	logic [`CNT_BITS-1:0] outstanding;
	logic                 aw_hs;
	logic                 b_ok;

	assign aw_hs = awvalid && awready;
	assign b_ok  = bvalid && (bresp == 2'b00);  // OKAY

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outstanding <= '0;
			bus_error   <= 1'b0;
		end else begin
			case ({aw_hs, b_ok})
				2'b10:   outstanding <= outstanding + `CNT_BITS'd1;
				2'b01:   if (outstanding != '0) outstanding <= outstanding - `CNT_BITS'd1;
				default: outstanding <= outstanding;  // none, or one in and one out
			endcase
			// error resp, or a resp with nothing in flight
			if (bvalid && (bresp != 2'b00 || outstanding == '0)) begin
				bus_error <= 1'b1;  // sticky
			end
		end
	end

	assign drained = (outstanding == '0);

endmodule

`default_nettype wire

/* tbl_init_ctrl.sv */
// table init controller
// walks the att or list entries, one aw then one w transfer each,
// then waits for all responses before flagging the mode done
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module tbl_init_ctrl
	import hawk_tbl_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 init_att,
	input  logic                 init_list,
	input  logic                 awready,
	input  logic                 wready,
	input  logic                 drained,
	output logic                 awvalid,
	output logic                 wvalid,
	output logic                 load,
	output init_mode_e           mode,
	output logic [`CNT_BITS-1:0] entry_idx,
	output logic                 init_att_done,
	output logic                 init_list_done,
	output logic                 pgwr_ready,
	output logic [`PTR_BITS-1:0] free_list_head,
	output logic [`PTR_BITS-1:0] free_list_tail
);

	ctrl_state_e          state_q, state_d;
	logic [`CNT_BITS-1:0] entry_last;  // last index of the current table
	logic                 in_init;
	logic                 aw_hs, w_hs;
	logic                 mode_done;

	assign aw_hs      = awvalid && awready;
	assign w_hs       = wvalid && wready;
	assign in_init    = (state_q == INIT_ATT) || (state_q == INIT_LIST);
	assign entry_last = (mode == MODE_LIST) ? `CNT_BITS'(`LIST_ENTRY_CNT) :
		`CNT_BITS'(`ATT_ENTRY_CNT);

	// builder captures the next entry while aw is idle
	assign load       = in_init && !awvalid && (entry_idx <= entry_last);
	assign mode_done  = (state_q == WAIT_BRESP) && drained;
	assign pgwr_ready = (state_q == IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (init_att && !init_att_done) begin
					state_d = INIT_ATT;  // att wins over list
				end else if (init_list && !init_list_done) begin
					state_d = INIT_LIST;
				end
			end
			INIT_ATT, INIT_LIST: begin
				if (aw_hs) begin
					state_d = (state_q == INIT_ATT) ? WAIT_ATT : WAIT_LIST;
				end else if (!awvalid && entry_idx > entry_last) begin
					state_d = WAIT_BRESP;  // all entries issued
				end
			end
			WAIT_ATT:   if (w_hs) state_d = INIT_ATT;
			WAIT_LIST:  if (w_hs) state_d = INIT_LIST;
			WAIT_BRESP: if (drained) state_d = IDLE;
			default:    state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= IDLE;
			mode           <= MODE_ATT;
			entry_idx      <= '0;
			awvalid        <= 1'b0;
			wvalid         <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
			free_list_head <= '0;  // null
			free_list_tail <= '0;
		end else begin
			state_q <= state_d;

			// mode start, index is 1-based
			if (state_q == IDLE && state_d != IDLE) begin
				entry_idx <= `CNT_BITS'd1;
				mode      <= (state_d == INIT_LIST) ? MODE_LIST : MODE_ATT;
			end else if (w_hs) begin
				entry_idx <= entry_idx + `CNT_BITS'd1;
			end

			if (load) begin
				awvalid <= 1'b1;  // address ready from builder next cycle
			end else if (aw_hs) begin
				awvalid <= 1'b0;
			end

			if (aw_hs) begin
				wvalid <= 1'b1;  // data follows the address
			end else if (w_hs) begin
				wvalid <= 1'b0;
			end

			// done flags stay set until reset
			if (mode_done && mode == MODE_ATT) begin
				init_att_done <= 1'b1;
			end
			if (mode_done && mode == MODE_LIST) begin
				init_list_done <= 1'b1;
				free_list_head <= `PTR_BITS'd1;  // whole table is one free list
				free_list_tail <= `PTR_BITS'(`LIST_ENTRY_CNT);
			end
		end
	end

endmodule

`default_nettype wire

/* hawk_tbl_init.sv */
// hawk table init write master
// initializes the att table and the free list over a single-beat
// aw/w/b write interface
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module hawk_tbl_init
	import hawk_tbl_pkg::*;
#(
	parameter int PWRUP_UNCOMP = 0
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  init_att,
	input  logic                  init_list,
	// write channels
	input  logic                  awready,
	input  logic                  wready,
	input  logic                  bvalid,
	input  logic [1:0]            bresp,
	output logic                  awvalid,
	output logic [`ADDR_BITS-1:0] awaddr,
	output logic                  wvalid,
	output logic [`LINE_BITS-1:0] wdata,
	output logic [`STRB_BITS-1:0] wstrb,
	// status
	output logic                  init_att_done,
	output logic                  init_list_done,
	output logic                  pgwr_ready,
	output logic                  bus_error,
	output logic [`PTR_BITS-1:0]  free_list_head,
	output logic [`PTR_BITS-1:0]  free_list_tail
);

	logic                 load;
	init_mode_e           mode;
	logic [`CNT_BITS-1:0] entry_idx;
	logic                 drained;

	tbl_init_ctrl i_ctrl (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.awready        (awready),
		.wready         (wready),
		.drained        (drained),
		.awvalid        (awvalid),
		.wvalid         (wvalid),
		.load           (load),
		.mode           (mode),
		.entry_idx      (entry_idx),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done),
		.pgwr_ready     (pgwr_ready),
		.free_list_head (free_list_head),
		.free_list_tail (free_list_tail)
	);

	tbl_line_builder #(
		.PWRUP_UNCOMP (PWRUP_UNCOMP)
	) i_builder (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.load      (load),
		.mode      (mode),
		.entry_idx (entry_idx),
		.awaddr    (awaddr),
		.wdata     (wdata),
		.wstrb     (wstrb)
	);

	// drained holds WAIT_BRESP until every b has come back
	wr_resp_tracker i_resp (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.awvalid   (awvalid),
		.awready   (awready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.drained   (drained),
		.bus_error (bus_error)
	);

endmodule

`default_nettype wire

/* hawk_tbl_init_assertions.sv */
// write channel protocol checks for the hawk table init master
// aw and w hold until accepted, never both valid at once
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module hawk_tbl_init_assertions (
	input logic                  clk_i,
	input logic                  rst_ni,
	input logic                  awvalid,
	input logic                  awready,
	input logic [`ADDR_BITS-1:0] awaddr,
	input logic                  wvalid,
	input logic                  wready,
	input logic [`LINE_BITS-1:0] wdata
);

	int unsigned fail_cnt = 0;  // read by the testbench

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			fail_cnt++;
			$error("awvalid dropped or awaddr changed before awready");
		end

	w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			fail_cnt++;
			$error("wvalid dropped or wdata changed before wready");
		end

	aw_w_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(awvalid && wvalid))  // one channel at a time
		else begin
			fail_cnt++;
			$error("awvalid and wvalid high together");
		end

endmodule

bind hawk_tbl_init hawk_tbl_init_assertions i_protocol (
	.clk_i   (clk_i),
	.rst_ni  (rst_ni),
	.awvalid (awvalid),
	.awready (awready),
	.awaddr  (awaddr),
	.wvalid  (wvalid),
	.wready  (wready),
	.wdata   (wdata)
);

`default_nettype wire

/* tb_hawk_tbl_init.sv */
// testbench for the hawk table init write master
// random aw/w back-pressure and delayed b responses with each write checked
// against a model of the att and free list entry formats
`timescale 1ns/100ps
`default_nettype none
`include "hawk_tbl_config.svh"

module tb_hawk_tbl_init;

	localparam int          RESET_CYCLES    = 16;
	localparam int          TOTAL_WRITES    = `ATT_ENTRY_CNT + `LIST_ENTRY_CNT;
	localparam int          WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 40 * TOTAL_WRITES) + 100;
	localparam logic [31:0] LFSR_SEED       = 32'h8c907248;
	localparam logic [31:0] LFSR_TAPS       = 32'h80200003;  // x^32+x^22+x^2+x+1

	logic                  clk_i;
	logic                  rst_ni;
	logic                  init_att;
	logic                  init_list;
	logic                  awready;
	logic                  wready;
	logic                  bvalid;
	logic [1:0]            bresp;
	logic                  awvalid;
	logic [`ADDR_BITS-1:0] awaddr;
	logic                  wvalid;
	logic [`LINE_BITS-1:0] wdata;
	logic [`STRB_BITS-1:0] wstrb;
	logic                  init_att_done;
	logic                  init_list_done;
	logic                  pgwr_ready;
	logic                  bus_error;
	logic [`PTR_BITS-1:0]  free_list_head;
	logic [`PTR_BITS-1:0]  free_list_tail;

	logic [31:0] lfsr_state;
	int          resp_q[$];  // cycles left before each pending b
	int          wr_cnt;     // writes seen since reset with att first then list
	int          b_returned;
	logic        inject_err;
	logic        att_done_q;
	logic        list_done_q;
	string       test_name;

	hawk_tbl_init #(
		.PWRUP_UNCOMP (1)
	) i_dut (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.awready        (awready),
		.wready         (wready),
		.bvalid         (bvalid),
		.bresp          (bresp),
		.awvalid        (awvalid),
		.awaddr         (awaddr),
		.wvalid         (wvalid),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done),
		.pgwr_ready     (pgwr_ready),
		.bus_error      (bus_error),
		.free_list_head (free_list_head),
		.free_list_tail (free_list_tail)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);  // galois form
	endfunction

	function automatic logic next_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// expected write k counts att entries 1..N first and then list entries
	task automatic build_expected(input int k, output logic [`ADDR_BITS-1:0] addr,
		output logic [`LINE_BITS-1:0] data, output logic [`STRB_BITS-1:0] strb);
		int           idx;
		int           slot;
		logic [63:0]  page;
		logic [127:0] ent;
		data = '0;
		strb = '0;
		ent  = '0;
		if (k < `ATT_ENTRY_CNT) begin
			idx       = k + 1;
			slot      = (idx - 1) % `ATT_PER_LINE;
			page      = (`HAWK_PPA_START >> 12) + 64'(idx - 1);
			ent[3:0]  = 4'd1;         // uncompressed
			ent[55:4] = page[51:0];   // own page
			addr      = `HAWK_ATT_START + 64'(64 * ((idx - 1) / `ATT_PER_LINE));
			data[slot*64 +: 64] = ent[63:0];
			strb[slot*8 +: 8]   = 8'hff;
		end else begin
			idx          = k - `ATT_ENTRY_CNT + 1;
			slot         = (idx - 1) % `LIST_PER_LINE;
			page         = (`HAWK_PPA_START >> 12) + 64'(idx - 1);
			ent[23:0]    = (idx == `LIST_ENTRY_CNT) ? 24'd0 : 24'(idx + 1);  // next is null at tail
			ent[47:24]   = 24'(idx - 1);  // prev
			ent[113:72]  = page[41:0];
			addr         = `HAWK_LIST_START + 64'(64 * ((idx - 1) / `LIST_PER_LINE));
			data[slot*128 +: 128] = ent;
			strb[slot*16 +: 16]   = 16'hffff;
		end
	endtask

	// sampled mid-cycle so a handshake seen here completes at the next edge
	task automatic monitor_cycle();
		logic [`ADDR_BITS-1:0] e_addr;
		logic [`LINE_BITS-1:0] e_data;
		logic [`STRB_BITS-1:0] e_strb;
		int                    delay;
		build_expected(wr_cnt, e_addr, e_data, e_strb);
		assert (i_dut.i_protocol.fail_cnt == 0)
			else abort_run("write channel protocol assertion failed");
		if (awvalid || wvalid) begin
			assert (!pgwr_ready) else abort_run($sformatf(
				"mismatch %s pgwr_ready expected 0 actual %0d", test_name, pgwr_ready));
		end
		if (awvalid && awready) begin
			assert (wr_cnt < TOTAL_WRITES)
				else abort_run($sformatf("%s: write issued after both tables were done", test_name));
			assert (wr_cnt < `ATT_ENTRY_CNT || init_att_done) else abort_run($sformatf(
				"%s: list write started before att init was done", test_name));
			assert (awaddr == e_addr) else abort_run($sformatf(
				"mismatch %s write %0d awaddr expected %h actual %h", test_name, wr_cnt, e_addr, awaddr));
		end
		if (wvalid && wready) begin
			assert (wstrb == e_strb) else abort_run($sformatf(
				"mismatch %s write %0d wstrb expected %h actual %h", test_name, wr_cnt, e_strb, wstrb));
			assert (wdata == e_data) else abort_run($sformatf(
				"mismatch %s write %0d wdata expected %h actual %h", test_name, wr_cnt, e_data, wdata));
			delay = 2 * next_bit();
			delay = delay + next_bit();  // 0..3 cycles
			resp_q.push_back(delay);
			wr_cnt++;
		end
		if (init_att_done && !att_done_q) begin
			assert (wr_cnt == `ATT_ENTRY_CNT) else abort_run($sformatf(
				"mismatch %s att writes expected %0d actual %0d", test_name, `ATT_ENTRY_CNT, wr_cnt));
			assert (b_returned == wr_cnt)
				else abort_run($sformatf("%s: att done rose with responses still pending", test_name));
			assert (pgwr_ready) else abort_run($sformatf(
				"mismatch %s pgwr_ready expected 1 actual %0d", test_name, pgwr_ready));
		end
		if (init_list_done && !list_done_q) begin
			assert (wr_cnt == TOTAL_WRITES) else abort_run($sformatf(
				"mismatch %s total writes expected %0d actual %0d", test_name, TOTAL_WRITES, wr_cnt));
			assert (b_returned == wr_cnt)
				else abort_run($sformatf("%s: list done rose with responses still pending", test_name));
			assert (pgwr_ready) else abort_run($sformatf(
				"mismatch %s pgwr_ready expected 1 actual %0d", test_name, pgwr_ready));
			assert (free_list_head == 24'd1) else abort_run($sformatf(
				"mismatch %s free_list_head expected 1 actual %0d", test_name, free_list_head));
			assert (free_list_tail == `LIST_ENTRY_CNT) else abort_run($sformatf(
				"mismatch %s free_list_tail expected %0d actual %0d", test_name, `LIST_ENTRY_CNT,
				free_list_tail));
		end
		if (!init_list_done) begin
			assert (free_list_head == '0 && free_list_tail == '0)
				else abort_run($sformatf("%s: free list set before list init was done", test_name));
		end
		att_done_q  = init_att_done;
		list_done_q = init_list_done;
	endtask

	// random readies and in-order b responses of at most one per cycle
	task automatic drive_cycle();
		awready = next_bit();
		wready  = next_bit();
		bvalid  = 1'b0;
		bresp   = 2'b00;
		if (inject_err) begin
			bvalid     = 1'b1;
			bresp      = 2'b10;  // slverr
			inject_err = 1'b0;
		end else if (resp_q.size() > 0 && resp_q[0] == 0) begin
			void'(resp_q.pop_front());
			bvalid = 1'b1;
			b_returned++;
		end
		foreach (resp_q[i]) begin
			if (resp_q[i] > 0) begin
				resp_q[i]--;
			end
		end
	endtask

	task automatic wait_drive_slot();
		@(posedge clk_i);
		#2;
	endtask

	task automatic apply_reset();
		rst_ni     = 1'b0;
		wr_cnt     = 0;
		b_returned = 0;
		resp_q.delete();
		repeat (RESET_CYCLES) @(posedge clk_i);
		#2 rst_ni = 1'b1;
	endtask

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;  // 20 ns
	end

	initial begin
		forever begin
			@(negedge clk_i);
			monitor_cycle();
			wait_drive_slot();
			drive_cycle();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		abort_run($sformatf("timeout after %0d cycles in %s", WATCHDOG_CYCLES, test_name));
	end

	initial begin
		rst_ni      = 1'b0;
		init_att    = 1'b0;
		init_list   = 1'b0;
		awready     = 1'b0;
		wready      = 1'b0;
		bvalid      = 1'b0;
		bresp       = 2'b00;
		lfsr_state  = LFSR_SEED;
		inject_err  = 1'b0;
		att_done_q  = 1'b0;
		list_done_q = 1'b0;
		test_name   = "reset";
		apply_reset();
		@(negedge clk_i);
		assert (!awvalid && !wvalid && !init_att_done && !init_list_done && !bus_error && pgwr_ready)
			else abort_run("outputs not at their idle values after reset");

		// att alone and then the list
		wait_drive_slot();
		test_name = "att_init";
		init_att  = 1'b1;
		wait (init_att_done);
		repeat (4) @(negedge clk_i);
		assert (pgwr_ready && !awvalid)
			else abort_run("pgwr_ready did not return after att init");
		wait_drive_slot();
		test_name = "list_init";
		init_list = 1'b1;
		wait (init_list_done);
		repeat (20) @(negedge clk_i);

		// both requests held through reset so att must go first
		wait_drive_slot();
		test_name = "both_held";
		apply_reset();
		wait (init_att_done && init_list_done);
		repeat (20) @(negedge clk_i);  // monitor flags any extra write
		assert (wr_cnt == TOTAL_WRITES && !awvalid) else abort_run($sformatf(
			"mismatch %s writes expected %0d actual %0d", test_name, TOTAL_WRITES, wr_cnt));

		test_name = "bus_error";
		assert (!bus_error) else abort_run("bus_error set while only okay responses were returned");
		inject_err = 1'b1;
		repeat (3) @(negedge clk_i);
		assert (bus_error) else abort_run($sformatf(
			"mismatch %s bus_error expected 1 actual %0d", test_name, bus_error));

		if (i_dut.i_protocol.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run("write channel protocol assertion failed");
		end
	end

endmodule

`default_nettype wire

/* hawk_tbl_init.f */
+incdir+.
hawk_tbl_pkg.sv
tbl_line_builder.sv
wr_resp_tracker.sv
tbl_init_ctrl.sv
hawk_tbl_init.sv
hawk_tbl_init_assertions.sv
tb_hawk_tbl_init.sv

/* Bender.yml */
package:
  name: hawk_tbl_init

export_include_dirs:
  - .

sources:
  - files:
      - hawk_tbl_pkg.sv
      - tbl_line_builder.sv
      - wr_resp_tracker.sv
      - tbl_init_ctrl.sv
      - hawk_tbl_init.sv
  - target: test
    files:
      - hawk_tbl_init_assertions.sv
      - tb_hawk_tbl_init.sv
